// File: verilog/cnn_pkg.sv
package cnn_pkg;

  localparam int BYTE_W = 8;
  localparam int WORD_W = 32;
  localparam int ADDR_W = 32;
  localparam int LANES = WORD_W / BYTE_W;

  // conv geometry
  localparam int KSIZE = 5;
  localparam int KTAPS = KSIZE * KSIZE;
  localparam int IF_ROWS = 6;
  localparam int IF_COLS = 8;
  localparam int IF_WORDS = IF_ROWS * IF_COLS / LANES;
  localparam int NUM_WIN = 8;
  localparam int WIN_PER_GROUP = 4;
  localparam int ACC_W = 32;

  // lane 3 is the msb and holds the lowest byte index
  typedef union packed {
    logic [WORD_W-1:0] raw;
    logic [LANES-1:0][BYTE_W-1:0] lane;
  } word_t;

  typedef enum logic [2:0] {IDLE, LOAD, TILE, DRAIN, POOL, WRITE, DONE} state_t;

  function automatic int weight_words(int num_pe);
    return (num_pe * KTAPS + LANES - 1) / LANES;
  endfunction

  // wide enough for the load count plus its extra drain cycle
  function automatic int cnt_width(int num_pe);
    return $clog2(weight_words(num_pe) + 2);
  endfunction

endpackage

// File: verilog/cnn_ctrl.sv
`timescale 1ns/1ps

module cnn_ctrl
  import cnn_pkg::*;
#(
  parameter int NUM_PE = 8
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              i_start,
  output logic [ADDR_W-1:0]                 o_if_addr,
  output logic                              o_if_en,
  output logic [ADDR_W-1:0]                 o_w_addr,
  output logic                              o_w_en,
  output logic                              o_w_load,
  output logic                              o_if_load,
  output logic [cnt_width(NUM_PE)-1:0]      o_load_idx,
  output logic                              o_win_valid,
  output logic [$clog2(NUM_WIN)-1:0]        o_win_idx,
  output logic                              o_pe_shift,
  output logic                              o_pool_step,
  output logic [$clog2(NUM_PE)-1:0]         o_pool_idx,
  output logic                              o_pool_group,
  output logic                              o_wr_en,
  output logic [$clog2(NUM_PE)-1:0]         o_wr_idx,
  output logic                              o_done
);

  localparam int W_WORDS = weight_words(NUM_PE);
  localparam int CNT_W = cnt_width(NUM_PE);
  localparam int PIDX_W = $clog2(NUM_PE);

  state_t state;
  logic [CNT_W-1:0] cnt;
  logic group; // 0 = windows 1 2 5 6, 1 = windows 3 4 7 8
  logic last;
  logic [1:0] win_pipe; // window reg, then pe reg

  // end of the current phase
  always_comb begin
    case (state)
      LOAD:    last = (cnt == CNT_W'(W_WORDS)); // one extra cycle for the last word
      TILE:    last = (cnt == CNT_W'(WIN_PER_GROUP - 1));
      DRAIN:   last = (cnt == CNT_W'(1));
      POOL:    last = (cnt == CNT_W'(NUM_PE - 1));
      WRITE:   last = (cnt == CNT_W'(NUM_PE / 2 - 1));
      default: last = 1'b1;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
      cnt <= '0;
      group <= 1'b0;
    end else begin
      cnt <= last ? '0 : cnt + 1'b1;
      if (last) begin
        case (state)
          IDLE: begin
            if (i_start) begin
              state <= LOAD;
              group <= 1'b0;
            end
          end
          LOAD:  state <= TILE;
          TILE:  state <= DRAIN;
          DRAIN: state <= POOL;
          POOL: begin
            if (group) begin
              state <= WRITE;
            end else begin
              state <= TILE;
              group <= 1'b1;
            end
          end
          WRITE:   state <= DONE;
          default: state <= IDLE;
        endcase
      end
    end
  end

  // weights and activations are fetched side by side
  assign o_w_en = (state == LOAD) && (cnt < CNT_W'(W_WORDS));
  assign o_if_en = (state == LOAD) && (cnt < CNT_W'(IF_WORDS));
  assign o_w_addr = ADDR_W'(cnt);
  assign o_if_addr = ADDR_W'(cnt);

  assign o_win_valid = (state == TILE);
  assign o_win_idx = {cnt[1], group, cnt[0]}; // row, column pair, column
  assign o_pe_shift = win_pipe[1];

  assign o_pool_step = (state == POOL);
  assign o_pool_idx = cnt[PIDX_W-1:0];
  assign o_pool_group = group;

  assign o_wr_en = (state == WRITE);
  assign o_wr_idx = cnt[PIDX_W-1:0];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_w_load <= 1'b0;
      o_if_load <= 1'b0;
      o_load_idx <= '0;
      win_pipe <= '0;
      o_done <= 1'b0;
    end else begin
      o_w_load <= o_w_en; // bram data lands a cycle later
      o_if_load <= o_if_en;
      o_load_idx <= cnt;
      win_pipe <= {win_pipe[0], o_win_valid};
      o_done <= (state == DONE);
    end
  end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst) o_done |=> !o_done)
    else $error("o_done held high for two cycles");

  a_write_after_pool: assert property (@(posedge clk) disable iff (rst)
    $rose(o_wr_en) |-> $past(o_pool_step && o_pool_group))
    else $error("write phase entered before group 1 pooled");

endmodule

// File: verilog/cnn_fetch.sv
`timescale 1ns/1ps

module cnn_fetch
  import cnn_pkg::*;
#(
  parameter int NUM_PE = 8
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  word_t                                  i_w_dout,
  input  word_t                                  i_if_dout,
  input  logic                                   i_w_load,
  input  logic                                   i_if_load,
  input  logic [cnt_width(NUM_PE)-1:0]           i_load_idx,
  input  logic                                   i_win_valid,
  input  logic [$clog2(NUM_WIN)-1:0]             i_win_idx,
  output logic [KTAPS-1:0][BYTE_W-1:0]           o_window,
  output logic [NUM_PE*KTAPS-1:0][BYTE_W-1:0]    o_weights
);

  localparam int W_WORDS = weight_words(NUM_PE);
  localparam int W_BYTES = W_WORDS * LANES;
  localparam int IF_BYTES = IF_ROWS * IF_COLS;
  localparam int WIN_COLS = IF_COLS - KSIZE + 1; // window positions per row
  localparam int BASE_W = $clog2(IF_BYTES);

  logic [BYTE_W-1:0] w_cache [W_BYTES];
  logic [BYTE_W-1:0] if_cache [IF_BYTES];
  logic [BASE_W-1:0] win_base;

  // msb lane carries the first byte of each word
  always_ff @(posedge clk) begin
    if (i_w_load) begin
      for (int l = 0; l < LANES; l++) begin
        w_cache[LANES*i_load_idx + l] <= i_w_dout.lane[LANES-1-l];
      end
    end
    if (i_if_load) begin
      for (int l = 0; l < LANES; l++) begin
        if_cache[LANES*i_load_idx + l] <= i_if_dout.lane[LANES-1-l];
      end
    end
  end

  for (genvar b = 0; b < NUM_PE * KTAPS; b++) begin : g_wout
    assign o_weights[b] = w_cache[b];
  end

  // top-left byte of the selected window
  assign win_base = BASE_W'((i_win_idx / WIN_COLS) * IF_COLS + i_win_idx % WIN_COLS);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_window <= '0;
    end else if (i_win_valid) begin
      for (int r = 0; r < KSIZE; r++) begin
        for (int c = 0; c < KSIZE; c++) begin
          o_window[r*KSIZE + c] <= if_cache[win_base + r*IF_COLS + c];
        end
      end
    end else begin
      o_window <= '0; // idle pes see zeros
    end
  end

  a_load_range: assert property (@(posedge clk) disable iff (rst)
    i_w_load |-> (i_load_idx < W_WORDS))
    else $error("weight load index past the weight cache");

endmodule

// File: verilog/cnn_pe.sv
`timescale 1ns/1ps

module cnn_pe
  import cnn_pkg::*;
#(
  parameter int QUANT_SHIFT = 8
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [KTAPS-1:0][BYTE_W-1:0] i_window,
  input  logic [KTAPS-1:0][BYTE_W-1:0] i_weights,
  output logic [BYTE_W-1:0]            o_result
);

  localparam logic [ACC_W-1:0] BYTE_MAX = ACC_W'((1 << BYTE_W) - 1);

  logic signed [ACC_W-1:0] acc;
  logic [ACC_W-1:0] shifted;

  // unsigned activation times signed weight
  always_comb begin
    acc = '0;
    for (int t = 0; t < KTAPS; t++) begin
      acc = acc + $signed({1'b0, i_window[t]}) * $signed(i_weights[t]);
    end
  end

  // relu, then requantize
  assign shifted = acc[ACC_W-1] ? '0 : ($unsigned(acc) >> QUANT_SHIFT);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_result <= '0;
    end else if (shifted > BYTE_MAX) begin
      o_result <= {BYTE_W{1'b1}}; // saturate
    end else begin
      o_result <= shifted[BYTE_W-1:0];
    end
  end

endmodule

// File: verilog/cnn_pool.sv
`timescale 1ns/1ps

module cnn_pool
  import cnn_pkg::*;
#(
  parameter int NUM_PE = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [NUM_PE-1:0][BYTE_W-1:0] i_results,
  input  logic                          i_pe_shift,
  input  logic                          i_pool_step,
  input  logic [$clog2(NUM_PE)-1:0]     i_pool_idx,
  input  logic                          i_pool_group,
  input  logic                          i_wr_en,
  input  logic [$clog2(NUM_PE)-1:0]     i_wr_idx,
  output logic [ADDR_W-1:0]             o_tmp_addr,
  output logic                          o_tmp_we,
  output word_t                         o_tmp_din
);

  localparam int GROUPS = NUM_WIN / WIN_PER_GROUP;
  localparam int POOL_BYTES = GROUPS * NUM_PE;
  localparam int SLOT_W = $clog2(POOL_BYTES);

  logic [BYTE_W-1:0] store [NUM_PE][WIN_PER_GROUP]; // last four window results
  logic [BYTE_W-1:0] pooled [POOL_BYTES];
  logic [BYTE_W-1:0] pool_max;
  logic [SLOT_W-1:0] pool_slot;

  always_ff @(posedge clk) begin
    if (i_pe_shift) begin
      for (int p = 0; p < NUM_PE; p++) begin
        store[p][0] <= i_results[p];
        for (int d = 1; d < WIN_PER_GROUP; d++) begin
          store[p][d] <= store[p][d-1];
        end
      end
    end
  end

  // 2x2 max over the selected channel
  always_comb begin
    pool_max = store[i_pool_idx][0];
    for (int d = 1; d < WIN_PER_GROUP; d++) begin
      if (store[i_pool_idx][d] > pool_max) pool_max = store[i_pool_idx][d];
    end
  end

  assign pool_slot = SLOT_W'(i_pool_group * NUM_PE + i_pool_idx);

  always_ff @(posedge clk) begin
    if (i_pool_step) pooled[pool_slot] <= pool_max;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) o_tmp_we <= 1'b0;
    else o_tmp_we <= i_wr_en;
  end

  // four pooled bytes per word, lowest index in the msb lane
  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      o_tmp_addr <= ADDR_W'(i_wr_idx);
      for (int l = 0; l < LANES; l++) begin
        o_tmp_din.lane[LANES-1-l] <= pooled[LANES*i_wr_idx + l];
      end
    end
  end

  a_pool_idx: assert property (@(posedge clk) disable iff (rst)
    i_pool_step |-> (i_pool_idx < NUM_PE))
    else $error("pool index past the channel count");

endmodule

// File: verilog/cnn_top.sv
`timescale 1ns/1ps

module cnn_top
  import cnn_pkg::*;
#(
  parameter int NUM_PE = 8,
  parameter int QUANT_SHIFT = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_start,
  input  word_t             i_if_dout,
  input  word_t             i_w_dout,
  output logic [ADDR_W-1:0] o_if_addr,
  output logic              o_if_en,
  output logic [ADDR_W-1:0] o_w_addr,
  output logic              o_w_en,
  output logic [ADDR_W-1:0] o_tmp_addr,
  output logic              o_tmp_we,
  output word_t             o_tmp_din,
  output logic              o_done
);

  localparam int CNT_W = cnt_width(NUM_PE);
  localparam int PIDX_W = $clog2(NUM_PE);
  localparam int WIN_W = $clog2(NUM_WIN);

  logic w_load;
  logic if_load;
  logic [CNT_W-1:0] load_idx;
  logic win_valid;
  logic [WIN_W-1:0] win_idx;
  logic pe_shift;
  logic pool_step;
  logic [PIDX_W-1:0] pool_idx;
  logic pool_group;
  logic wr_en;
  logic [PIDX_W-1:0] wr_idx;
  logic [KTAPS-1:0][BYTE_W-1:0] window;
  logic [NUM_PE*KTAPS-1:0][BYTE_W-1:0] weights;
  logic [NUM_PE-1:0][BYTE_W-1:0] results;

  cnn_ctrl #(.NUM_PE(NUM_PE)) u_ctrl (
    .clk, .rst, .i_start,
    .o_if_addr, .o_if_en, .o_w_addr, .o_w_en,
    .o_w_load(w_load), .o_if_load(if_load), .o_load_idx(load_idx),
    .o_win_valid(win_valid), .o_win_idx(win_idx), .o_pe_shift(pe_shift),
    .o_pool_step(pool_step), .o_pool_idx(pool_idx), .o_pool_group(pool_group),
    .o_wr_en(wr_en), .o_wr_idx(wr_idx), .o_done
  );

  cnn_fetch #(.NUM_PE(NUM_PE)) u_fetch (
    .clk, .rst, .i_w_dout, .i_if_dout,
    .i_w_load(w_load), .i_if_load(if_load), .i_load_idx(load_idx),
    .i_win_valid(win_valid), .i_win_idx(win_idx),
    .o_window(window), .o_weights(weights)
  );

  // one pe per output channel, all sharing the window
  for (genvar p = 0; p < NUM_PE; p++) begin : g_pe
    cnn_pe #(.QUANT_SHIFT(QUANT_SHIFT)) u_pe (
      .clk, .rst,
      .i_window(window),
      .i_weights(weights[p*KTAPS +: KTAPS]),
      .o_result(results[p])
    );
  end

  cnn_pool #(.NUM_PE(NUM_PE)) u_pool (
    .clk, .rst, .i_results(results),
    .i_pe_shift(pe_shift), .i_pool_step(pool_step), .i_pool_idx(pool_idx),
    .i_pool_group(pool_group), .i_wr_en(wr_en), .i_wr_idx(wr_idx),
    .o_tmp_addr, .o_tmp_we, .o_tmp_din
  );

endmodule

// File: testbench/tb_cnn.sv
`timescale 1ns/1ps

module tb_cnn
  import cnn_pkg::*;
();

  localparam int NUM_PE = 8;
  localparam int QUANT_SHIFT = 8;
  localparam int W_WORDS = NUM_PE * KTAPS / 4;
  localparam int WR_WORDS = NUM_PE / 2;
  localparam int POOL_BYTES = 2 * NUM_PE;
  localparam int TIMEOUT = 500;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic i_start = 1'b0;
  word_t if_rdata = '0;
  word_t w_rdata = '0;
  logic [ADDR_W-1:0] o_if_addr, o_w_addr, o_tmp_addr;
  logic o_if_en, o_w_en, o_tmp_we, o_done;
  word_t o_tmp_din;

  logic [WORD_W-1:0] if_mem [IF_WORDS];
  logic [WORD_W-1:0] w_mem [W_WORDS];
  logic [WORD_W-1:0] tmp_mem [WR_WORDS];
  logic [31:0] rng;
  int errors = 0;
  int cases = 0;

  // filled only by the temporary BRAM monitor
  int cycle = 0;
  int wr_count = 0;
  int done_count = 0;
  int bad_addr = 0;
  int last_wr_cycle = 0;
  int done_cycle = 0;
  int addr_hits [WR_WORDS] = '{default: 0};

  cnn_top i_cnn_top (
    .clk, .rst, .i_start,
    .i_if_dout(if_rdata), .i_w_dout(w_rdata),
    .o_if_addr, .o_if_en, .o_w_addr, .o_w_en,
    .o_tmp_addr, .o_tmp_we, .o_tmp_din, .o_done
  );

  always #4 clk = ~clk;

  // read data one cycle after an enabled address
  always @(posedge clk) begin
    if (o_if_en && o_if_addr < IF_WORDS) if_rdata <= if_mem[o_if_addr];
    if (o_w_en && o_w_addr < W_WORDS) w_rdata <= w_mem[o_w_addr];
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (o_tmp_we) begin
      wr_count <= wr_count + 1;
      last_wr_cycle <= cycle;
      if (o_tmp_addr < WR_WORDS) begin
        tmp_mem[o_tmp_addr] <= o_tmp_din.raw;
        addr_hits[o_tmp_addr] <= addr_hits[o_tmp_addr] + 1;
      end else begin
        bad_addr <= bad_addr + 1;
      end
    end
    if (o_done) begin
      done_count <= done_count + 1;
      done_cycle <= cycle;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic random_word(output logic [31:0] v);
    rng = lcg_next(rng);
    v[31:16] = rng[31:16]; // low lcg bits are weak so only the top half is kept
    rng = lcg_next(rng);
    v[15:0] = rng[31:16];
  endtask

  // weights in -32..31 keep most sums away from the clamps
  function automatic logic [31:0] small_weights(input logic [31:0] v);
    logic [31:0] w;
    for (int l = 0; l < 4; l++) begin
      w[8*l +: 8] = {{2{v[8*l+5]}}, v[8*l +: 6]};
    end
    return w;
  endfunction

  task automatic fill_memories(input int mode);
    logic [31:0] v;
    for (int i = 0; i < IF_WORDS; i++) begin
      random_word(v);
      if_mem[i] = (mode == 2) ? 32'hffffffff : v;
    end
    for (int i = 0; i < W_WORDS; i++) begin
      random_word(v);
      case (mode)
        1: w_mem[i] = v | 32'h80808080; // sign bit set in every lane
        2: w_mem[i] = 32'h7f7f7f7f;
        default: w_mem[i] = small_weights(v);
      endcase
    end
  endtask

  // byte n of a memory sits in word n/4 with the first byte in the top lane
  function automatic int act_byte(input int n);
    return int'(if_mem[n/4][8*(3 - n%4) +: 8]);
  endfunction

  function automatic int weight_byte(input int n);
    byte signed b;
    b = w_mem[n/4][8*(3 - n%4) +: 8];
    return int'(b);
  endfunction

  function automatic logic [WR_WORDS-1:0][WORD_W-1:0] expected_words();
    logic [7:0] pooled [POOL_BYTES];
    logic [WR_WORDS-1:0][WORD_W-1:0] words;
    int acc;
    int q;
    int mx;
    for (int g = 0; g < 2; g++) begin
      for (int p = 0; p < NUM_PE; p++) begin
        mx = 0;
        for (int r = 0; r < 2; r++) begin
          for (int c = 2*g; c < 2*g + 2; c++) begin
            acc = 0;
            for (int t = 0; t < KTAPS; t++) begin
              acc += act_byte((r + t/KSIZE)*IF_COLS + c + t%KSIZE) * weight_byte(p*KTAPS + t);
            end
            q = (acc < 0) ? 0 : (acc >>> QUANT_SHIFT); // relu then requantize
            if (q > 255) q = 255;
            if (q > mx) mx = q;
          end
        end
        pooled[g*NUM_PE + p] = mx[7:0];
      end
    end
    for (int j = 0; j < WR_WORDS; j++) begin
      words[j] = {pooled[4*j], pooled[4*j+1], pooled[4*j+2], pooled[4*j+3]};
    end
    return words;
  endfunction

  task automatic report_mismatch(input string name, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("[ERROR] %s %s: expected 0x%08h actual 0x%08h", name, what, exp, act);
  endtask

  task automatic run_case(input string name, input int mode);
    logic [WR_WORDS-1:0][WORD_W-1:0] exp_words;
    int wr_before;
    int done_before;
    int bad_before;
    int hits_before [WR_WORDS];
    bit seen;
    cases++;
    fill_memories(mode);
    exp_words = expected_words();
    wr_before = wr_count;
    done_before = done_count;
    bad_before = bad_addr;
    for (int j = 0; j < WR_WORDS; j++) hits_before[j] = addr_hits[j];
    @(posedge clk);
    i_start <= 1'b1;
    @(posedge clk);
    i_start <= 1'b0;
    seen = 1'b0;
    for (int n = 0; n < TIMEOUT && !seen; n++) begin
      @(posedge clk);
      seen = o_done;
    end
    if (!seen) begin
      errors++;
      $display("%s: o_done did not rise within %0d cycles of the start pulse", name, TIMEOUT);
      $display("cases: %0d  errors: %0d", cases, errors);
      $display("test failed");
      $finish;
    end
    repeat (4) @(posedge clk); // room for a stray second done
    if (wr_count - wr_before != WR_WORDS)
      report_mismatch(name, "write count", WR_WORDS, wr_count - wr_before);
    if (done_count - done_before != 1)
      report_mismatch(name, "done pulses", 1, done_count - done_before);
    if (bad_addr != bad_before) begin
      errors++;
      $display("[ERROR] %s: a temporary write went past address %0d", name, WR_WORDS - 1);
    end
    if (last_wr_cycle >= done_cycle) begin
      errors++;
      $display("[ERROR] %s: o_done rose before the last temporary write", name);
    end
    for (int j = 0; j < WR_WORDS; j++) begin
      if (addr_hits[j] - hits_before[j] != 1)
        report_mismatch(name, $sformatf("writes at %0d", j), 1, addr_hits[j] - hits_before[j]);
      if (tmp_mem[j] !== exp_words[j])
        report_mismatch(name, $sformatf("word %0d", j), exp_words[j], tmp_mem[j]);
      if (mode == 1 && tmp_mem[j] !== 32'h0)
        report_mismatch(name, $sformatf("relu word %0d", j), 32'h0, tmp_mem[j]);
      if (mode == 2 && tmp_mem[j] !== 32'hffffffff)
        report_mismatch(name, $sformatf("saturated word %0d", j), 32'hffffffff, tmp_mem[j]);
    end
  endtask

  initial begin
    rng = 32'hc44a6153;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    // start stays low so nothing may move
    for (int n = 0; n < 20; n++) begin
      @(posedge clk);
      if ({o_if_en, o_w_en, o_tmp_we, o_done} !== 4'b0000)
        report_mismatch("reset", "enables", 32'h0, {o_if_en, o_w_en, o_tmp_we, o_done});
    end
    run_case("random_a", 0);
    run_case("relu", 1);
    run_case("saturate", 2);
    run_case("random_b", 0);
    $display("cases: %0d  errors: %0d", cases, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: build.f
verilog/cnn_pkg.sv
verilog/cnn_ctrl.sv
verilog/cnn_fetch.sv
verilog/cnn_pe.sv
verilog/cnn_pool.sv
verilog/cnn_top.sv
testbench/tb_cnn.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cnn -f build.f -o sim_cnn
./obj_dir/sim_cnn > sim.log 2>&1
cat sim.log

if grep -q "test failed" sim.log; then
  exit 1
fi
exit 0
